// ==== src.f ====
+incdir+include
logic/gb_bus_pkg.sv
logic/gb_oam_dma.sv
logic/gb_addr_decode.sv
logic/gb_mem_access.sv
logic/gb_bus_top.sv
dv/gb_bus_assert.sv
dv/gb_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory-bus testbench

VERILATOR  ?= verilator
TOP        ?= gb_bus_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing --assert
RUN_FLAGS  ?= +verilator+error+limit+100
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/gb_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gb_bus_defines.svh"

module gb_bus_tb;
    import gb_bus_pkg::*;

    localparam int CLK_HALF       = 10;                      // 20 ns period
    localparam int RESET_CYCLES   = 5;
    localparam int EST_CYCLES     = 1200;                    // All six tests, roughly
    localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES + 600;
    localparam bus_req_t IDLE_REQ = '0;

    logic      clk = 1'b0;
    logic      rst;
    bus_req_t  cpu_req;
    data_t     din;
    data_t     brom_data;
    data_t     key;
    irq_t      irq_req;
    cart_bus_t cart;
    addr_t     brom_addr;
    data_t     rd_data;
    logic      rd_valid;
    logic      cpu_blocked;
    oam_wr_t   oam_wr;
    irq_t      irq_pending;

    // Reference state
    data_t       wram_model [8192];
    irq_t        if_model = '0;
    irq_t        ie_model = '0;
    logic [31:0] rng      = 32'h21e6_83db;
    int          errors   = 0;
    int          cycles   = 0;

    gb_bus_top DUT (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .din         (din),
        .brom_data   (brom_data),
        .key         (key),
        .irq_req     (irq_req),
        .cart        (cart),
        .brom_addr   (brom_addr),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .cpu_blocked (cpu_blocked),
        .oam_wr      (oam_wr),
        .irq_pending (irq_pending)
    );

    always #(CLK_HALF) clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic data_t cart_byte(input addr_t a);
        return a[7:0] ^ 8'hA5;  // Cart ROM and RAM pattern
    endfunction

    function automatic data_t brom_byte(input addr_t a);
        return a[7:0] ^ 8'h3C;  // Boot ROM pattern
    endfunction

    function automatic bus_req_t make_req(input addr_t a, input data_t d,
                                          input logic rd, input logic wr);
        bus_req_t r;
        r.addr  = a;
        r.wdata = d;
        r.rd    = rd;
        r.wr    = wr;
        r.dma   = 1'b0;
        return r;
    endfunction

    task automatic compare_byte(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: %s = %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    // One strobe cycle, then idle
    task automatic bus_write(input addr_t a, input data_t d);
        @(negedge clk);
        cpu_req = make_req(a, d, 1'b0, 1'b1);
        @(negedge clk);
        cpu_req = IDLE_REQ;
    endtask

    task automatic cpu_read(input addr_t a, output data_t d, output logic saw_cart_rd);
        int wait_cyc;
        wait_cyc    = 0;
        saw_cart_rd = 1'b0;
        @(negedge clk);
        cpu_req = make_req(a, 8'h00, 1'b1, 1'b0);
        @(negedge clk);
        cpu_req = IDLE_REQ;
        assert (brom_addr === a) else begin  // Boot ROM sees the decoded address
            errors++;
            $display("ERROR at %0t: brom_addr = %04h, expected %04h", $time, brom_addr, a);
        end
        while (!rd_valid && wait_cyc < 4) begin  // Wait for the response pulse
            saw_cart_rd = saw_cart_rd | cart.rd;
            @(negedge clk);
            wait_cyc++;
        end
        assert (rd_valid) else begin
            errors++;
            $display("No read response for address %04h at %0t", a, $time);
        end
        d = rd_data;
    endtask

    task automatic read_expect(input addr_t a, input data_t exp);
        data_t d;
        logic  saw;
        cpu_read(a, d, saw);
        compare_byte($sformatf("rd_data[%04h]", a), d, exp);
    endtask

    task automatic pulse_irq(input irq_t v);
        @(negedge clk);
        irq_req = v;
        @(negedge clk);
        irq_req  = '0;
        if_model = if_model | v;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic wram_readback();
        addr_t      wq[$];
        wram_addr_t idx;
        addr_t      a;
        int         n;
        for (n = 0; n < 32; n++) begin
            rng = xorshift(rng);
            idx = rng[12:0];
            if (idx >= 13'h1E00) idx = idx - 13'h1000;  // Keep echo inside E000-FDFF
            a   = 16'hC000 + {3'b000, idx};
            rng = xorshift(rng);
            wram_model[idx] = rng[7:0];
            bus_write(a, rng[7:0]);
            wq.push_back(a);
        end
        foreach (wq[i]) begin
            a   = wq[i];
            idx = a[12:0];
            read_expect(a, wram_model[idx]);
            read_expect(a + 16'h2000, wram_model[idx]);  // Echo alias
        end
    endtask

    task automatic boot_overlay();
        data_t d;
        logic  saw;
        cpu_read(16'h0040, d, saw);
        compare_byte("rd_data boot", d, brom_byte(16'h0040));
        assert (!saw) else begin
            errors++;
            $display("Cart read strobe seen while boot overlay on, at %0t", $time);
        end
        bus_write(`MMIO_BOOTSTRAP, 8'h01);
        cpu_read(16'h0040, d, saw);
        compare_byte("rd_data cart", d, cart_byte(16'h0040));
        assert (saw) else begin
            errors++;
            $display("No cart read strobe after boot overlay off, at %0t", $time);
        end
    endtask

    task automatic irq_regs();
        int n;
        rng      = xorshift(rng);
        ie_model = rng[4:0];
        bus_write(`MMIO_IE, {3'b000, ie_model});
        read_expect(`MMIO_IE, {3'b111, ie_model});
        for (n = 0; n < 6; n++) begin
            rng = xorshift(rng);
            pulse_irq(rng[4:0]);
            read_expect(`MMIO_IF, {3'b111, if_model});
            compare_byte("irq_pending", {3'b000, irq_pending}, {3'b000, if_model & ie_model});
        end
        bus_write(`MMIO_IF, 8'h0A);  // Replace, not merge
        if_model = 5'h0A;
        read_expect(`MMIO_IF, {3'b111, if_model});
        compare_byte("irq_pending", {3'b000, irq_pending}, {3'b000, if_model & ie_model});
        bus_write(`MMIO_IF, 8'h00);
        if_model = '0;
        read_expect(`MMIO_IF, 8'hE0);
    endtask

    task automatic joypad_read();
        int         s;
        int         n;
        logic [1:0] sel;
        data_t      k;
        logic [3:0] dir_n;
        logic [3:0] btn_n;
        for (s = 0; s < 4; s++) begin
            sel = 2'(s);
            bus_write(`MMIO_JOYSTICK, {2'b00, sel, 4'h0});
            for (n = 0; n < 4; n++) begin
                rng = xorshift(rng);
                k   = rng[7:0];
                @(negedge clk);
                key   = k;
                dir_n = sel[0] ? 4'hF : ~k[3:0];  // Active-low nibbles
                btn_n = sel[1] ? 4'hF : ~k[7:4];
                read_expect(`MMIO_JOYSTICK, {2'b11, sel, dir_n & btn_n});
            end
        end
    endtask

    task automatic oam_dma_copy();
        int   k;
        int   cyc;
        int   oam_cnt;
        int   lost_rd;
        int   blocked_rds;
        logic done;
        for (k = 0; k < 160; k++) begin
            rng = xorshift(rng);
            wram_model[13'h0100 + 13'(k)] = rng[7:0];
            bus_write(16'hC100 + 16'(k), rng[7:0]);
        end
        bus_write(`MMIO_DMA, 8'hC1);
        cyc         = 0;
        oam_cnt     = 0;
        lost_rd     = 0;
        blocked_rds = 0;
        done        = 1'b0;
        while (!done && cyc < 400) begin
            @(negedge clk);
            cyc++;
            if (rd_valid) lost_rd++;
            if (oam_wr.we) begin
                compare_byte("oam_wr.idx", oam_wr.idx, 8'(oam_cnt));
                compare_byte("oam_wr.data", oam_wr.data, wram_model[13'h0100 + 13'(oam_cnt)]);
                oam_cnt++;
            end
            // Occasional CPU read that must be dropped
            if (cpu_blocked && cyc % 20 == 0) begin
                cpu_req = make_req(16'hC100 + 16'(cyc), 8'h00, 1'b1, 1'b0);
                blocked_rds++;
            end else begin
                cpu_req = IDLE_REQ;
            end
            done = (cyc > 4) && !cpu_blocked;
        end
        repeat (3) begin
            @(negedge clk);
            if (rd_valid) lost_rd++;
        end
        assert (oam_cnt == 160 && blocked_rds > 0) else begin
            errors++;
            $display("DMA wrote %0d OAM bytes, %0d blocked reads tried", oam_cnt, blocked_rds);
        end
        assert (lost_rd == 0) else begin
            errors++;
            $display("%0d read responses while the CPU was blocked", lost_rd);
        end
        read_expect(16'hC150, wram_model[13'h0150]);
    endtask

    task automatic cart_and_open_bus();
        @(negedge clk);
        cpu_req = make_req(16'hA010, 8'h5A, 1'b0, 1'b1);
        @(negedge clk);
        cpu_req = IDLE_REQ;
        assert (cart.wr && cart.cs && !cart.rd) else begin
            errors++;
            $display("Cart strobes wrong during write to A010 at %0t", $time);
        end
        assert (cart.addr === 16'hA010) else begin
            errors++;
            $display("ERROR at %0t: cart.addr = %04h, expected %04h", $time, cart.addr, 16'hA010);
        end
        compare_byte("cart.dout", cart.dout, 8'h5A);
        read_expect(16'hFF44, 8'hFF);  // LCD register, unmapped here
        read_expect(16'h1234, cart_byte(16'h1234));
    endtask

    // Cart and boot ROM answer from the address they see
    initial begin
        din       = 8'h00;
        brom_data = 8'h00;
        forever begin
            @(negedge clk);
            din       = cart_byte(cart.addr);
            brom_data = brom_byte(brom_addr);
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int assert_fails;
        rst     = 1'b1;
        cpu_req = IDLE_REQ;
        key     = 8'h00;
        irq_req = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        wram_readback();
        boot_overlay();
        irq_regs();
        joypad_read();
        oam_dma_copy();
        cart_and_open_bus();
        repeat (3) @(negedge clk);
        assert_fails = DUT.u_assert.fail_cnt;
        $display("Errors: %0d value checks, %0d bound assertions", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/gb_bus_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_bus_assert (
    input logic                  clk,
    input logic                  rst,
    input gb_bus_pkg::bus_req_t  cpu_req,
    input logic                  cpu_blocked,
    input logic                  rd_valid,
    input gb_bus_pkg::cart_bus_t cart,
    input gb_bus_pkg::oam_wr_t   oam_wr
);

    int   fail_cnt = 0;  // Failed assertions so far
    logic rd_taken;      // CPU read that decode keeps

    assign rd_taken = cpu_req.rd & ~cpu_blocked;

    ////////////////////////////////////////
    // Read response timing
    ////////////////////////////////////////
    rd_two_cycles: assert property (@(posedge clk) disable iff (rst)
        $past(rd_taken, 2) |-> rd_valid)
        else begin
            fail_cnt++;
            $error("rd_valid missing two cycles after an accepted read");
        end

    // No response without its read
    rd_has_source: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(rd_taken, 2))
        else begin
            fail_cnt++;
            $error("rd_valid without an accepted read two cycles before");
        end

    ////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////
    oam_only_in_dma: assert property (@(posedge clk) disable iff (rst)
        oam_wr.we |-> cpu_blocked)
        else begin
            fail_cnt++;
            $error("oam_wr strobe while the CPU owns the bus");
        end

    cart_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(cart.wr && cart.rd))
        else begin
            fail_cnt++;
            $error("cart wr and rd high together");
        end

    // First reset edge clears the pipeline, so check from the second
    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(rd_valid || cart.wr || cart.rd || cart.cs || oam_wr.we))
        else begin
            fail_cnt++;
            $error("strobe active during reset");
        end

endmodule

bind gb_bus_top gb_bus_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (cpu_req),
    .cpu_blocked (cpu_blocked),
    .rd_valid    (rd_valid),
    .cart        (cart),
    .oam_wr      (oam_wr)
);

`default_nettype wire

// ==== logic/gb_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_bus_top (
    input  logic                  clk,
    input  logic                  rst,
    input  gb_bus_pkg::bus_req_t  cpu_req,
    input  gb_bus_pkg::data_t     din,
    input  gb_bus_pkg::data_t     brom_data,
    input  gb_bus_pkg::data_t     key,
    input  gb_bus_pkg::irq_t      irq_req,
    output gb_bus_pkg::cart_bus_t cart,
    output gb_bus_pkg::addr_t     brom_addr,
    output gb_bus_pkg::data_t     rd_data,
    output logic                  rd_valid,
    output logic                  cpu_blocked,  // DMA holds the bus
    output gb_bus_pkg::oam_wr_t   oam_wr,
    output gb_bus_pkg::irq_t      irq_pending
);
    import gb_bus_pkg::*;

    bus_req_t dma_req;
    dec_req_t dec_req;
    logic     dma_busy;
    logic     boot_en;
    logic     rsp_valid;
    logic     rsp_dma;
    data_t    rsp_data;
    logic     dma_start;
    data_t    dma_page;

    gb_oam_dma u_dma (
        .clk       (clk),
        .rst       (rst),
        .dma_start (dma_start),
        .dma_page  (dma_page),
        .rsp_valid (rsp_valid),
        .rsp_dma   (rsp_dma),
        .rsp_data  (rsp_data),
        .dma_req   (dma_req),
        .dma_busy  (dma_busy),
        .oam_wr    (oam_wr)
    );

    // Stage 1
    gb_addr_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .dma_req  (dma_req),
        .dma_busy (dma_busy),
        .boot_en  (boot_en),
        .dec_req  (dec_req)
    );

    // Stage 2
    gb_mem_access u_access (
        .clk         (clk),
        .rst         (rst),
        .dec_req     (dec_req),
        .din         (din),
        .brom_data   (brom_data),
        .key         (key),
        .irq_req     (irq_req),
        .cart        (cart),
        .brom_addr   (brom_addr),
        .boot_en     (boot_en),
        .rsp_valid   (rsp_valid),
        .rsp_dma     (rsp_dma),
        .rsp_data    (rsp_data),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .irq_pending (irq_pending)
    );

    // DMA responses stay internal
    assign rd_valid    = rsp_valid & ~rsp_dma;
    assign rd_data     = rsp_data;
    assign cpu_blocked = dma_busy;

endmodule

`default_nettype wire

// ==== logic/gb_mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gb_bus_defines.svh"

module gb_mem_access (
    input  logic                  clk,
    input  logic                  rst,
    input  gb_bus_pkg::dec_req_t  dec_req,
    input  gb_bus_pkg::data_t     din,        // Cart read data
    input  gb_bus_pkg::data_t     brom_data,
    input  gb_bus_pkg::data_t     key,        // 1 = pressed
    input  gb_bus_pkg::irq_t      irq_req,    // Single-cycle requests
    output gb_bus_pkg::cart_bus_t cart,
    output gb_bus_pkg::addr_t     brom_addr,
    output logic                  boot_en,
    output logic                  rsp_valid,
    output logic                  rsp_dma,
    output gb_bus_pkg::data_t     rsp_data,
    output logic                  dma_start,
    output gb_bus_pkg::data_t     dma_page,
    output gb_bus_pkg::irq_t      irq_pending
);
    import gb_bus_pkg::*;

    data_t      wram_mem [2**$bits(wram_addr_t)];
    logic       boot_off;     // FF50 bit 0
    irq_t       if_q;
    irq_t       ie_q;
    irq_t       if_next;
    logic [1:0] joy_sel;      // FF00 bits 5:4
    logic [3:0] joy_pressed;
    data_t      joy_rd;
    logic       in_cram;
    logic       cart_hit;
    logic       wr_en;

    assign wr_en    = dec_req.req.wr;
    assign cart_hit = (dec_req.region == CART);
    assign in_cram  = (dec_req.req.addr >= `MEM_CRAM_START) &&
                      (dec_req.req.addr <= `MEM_CRAM_END);

    ////////////////////////////////////////
    // External buses
    ////////////////////////////////////////
    always_comb begin
        cart.addr = dec_req.req.addr;
        cart.dout = dec_req.req.wdata;
        cart.wr   = wr_en & cart_hit;
        cart.rd   = dec_req.req.rd & cart_hit;
        cart.cs   = (dec_req.req.rd | wr_en) & cart_hit & in_cram;
    end

    assign brom_addr = dec_req.req.addr;  // Boot ROM is combinational outside
    assign boot_en   = ~boot_off;

    // Work RAM write port
    always_ff @(posedge clk) begin
        if (wr_en && dec_req.region == WRAM) wram_mem[dec_req.wram_addr] <= dec_req.req.wdata;
    end

    ////////////////////////////////////////
    // I/O registers
    ////////////////////////////////////////

    // New requests are never lost to a CPU write
    always_comb begin
        if_next = if_q | irq_req;
        if (wr_en && dec_req.region == IF) if_next = dec_req.req.wdata[4:0] | irq_req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            boot_off  <= 1'b0;  // Overlay on out of reset
            if_q      <= '0;
            ie_q      <= '0;
            joy_sel   <= '0;
            dma_start <= 1'b0;
        end else begin
            if_q      <= if_next;
            dma_start <= wr_en && dec_req.region == DMA;  // One-cycle kick
            if (wr_en && dec_req.region == BOOTSTRAP) boot_off <= dec_req.req.wdata[0];
            if (wr_en && dec_req.region == IE) ie_q <= dec_req.req.wdata[4:0];
            if (wr_en && dec_req.region == JOYPAD) joy_sel <= dec_req.req.wdata[5:4];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && dec_req.region == DMA) dma_page <= dec_req.req.wdata;
    end

    assign irq_pending = if_q & ie_q;

    // Selects are active low, pressed keys pull the nibble low
    always_comb begin
        joy_pressed = 4'b0000;
        if (!joy_sel[0]) joy_pressed = joy_pressed | key[3:0];  // Directions
        if (!joy_sel[1]) joy_pressed = joy_pressed | key[7:4];  // Buttons
        joy_rd = {2'b11, joy_sel, ~joy_pressed};
    end

    ////////////////////////////////////////
    // Read response
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_dma   <= 1'b0;
        end else begin
            rsp_valid <= dec_req.req.rd;
            rsp_dma   <= dec_req.req.dma;
        end
    end

    // Data only moves on reads
    always_ff @(posedge clk) begin
        if (dec_req.req.rd) begin
            case (dec_req.region)
                BOOT:      rsp_data <= brom_data;
                CART:      rsp_data <= din;
                WRAM:      rsp_data <= wram_mem[dec_req.wram_addr];
                JOYPAD:    rsp_data <= joy_rd;
                IF:        rsp_data <= {3'b111, if_q};  // Unused bits read high
                IE:        rsp_data <= {3'b111, ie_q};
                DMA:       rsp_data <= dma_page;
                BOOTSTRAP: rsp_data <= {7'h7F, boot_off};
                default:   rsp_data <= `OPEN_BUS;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/gb_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gb_bus_defines.svh"

module gb_addr_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  gb_bus_pkg::bus_req_t  cpu_req,
    input  gb_bus_pkg::bus_req_t  dma_req,
    input  logic                  dma_busy,  // DMA owns the bus
    input  logic                  boot_en,   // Boot ROM overlay active
    output gb_bus_pkg::dec_req_t  dec_req
);
    import gb_bus_pkg::*;

    bus_req_t   sel;        // Winning request
    logic       req_act;
    region_t    region;
    wram_addr_t wram_idx;

    // Inclusive range check, one compare
    function automatic logic in_range(addr_t a, addr_t lo, addr_t hi);
        addr_t span;
        addr_t off;
        span = hi - lo;
        off  = a - lo;
        return off <= span;
    endfunction

    ////////////////////////////////////////
    // Source select
    ////////////////////////////////////////
    always_comb begin
        if (dma_busy) begin
            sel = dma_req;      // CPU request is dropped
        end else begin
            sel     = cpu_req;
            sel.dma = 1'b0;     // Outside port never counts as DMA
        end
    end

    assign req_act = sel.rd | sel.wr;

    ////////////////////////////////////////
    // Address classification
    ////////////////////////////////////////
    always_comb begin
        if (boot_en && sel.addr <= `BOOT_END)
            region = BOOT;  // Overlay hides cart ROM
        else if (in_range(sel.addr, `MEM_CART_START, `MEM_CART_END) ||
                 in_range(sel.addr, `MEM_CRAM_START, `MEM_CRAM_END))
            region = CART;
        else if (in_range(sel.addr, `MEM_WRAM_START, `MEM_WRAM_END) ||
                 in_range(sel.addr, `MEM_ECHO_START, `MEM_ECHO_END))
            region = WRAM;
        else if (sel.addr == `MMIO_JOYSTICK)
            region = JOYPAD;
        else if (sel.addr == `MMIO_IF)
            region = IF;
        else if (sel.addr == `MMIO_IE)
            region = IE;
        else if (sel.addr == `MMIO_DMA)
            region = DMA;
        else if (sel.addr == `MMIO_BOOTSTRAP)
            region = BOOTSTRAP;
        else
            region = UNMAPPED;  // Video, VRAM, OAM, sound and the rest
    end

    // Both bases sit on 8 KiB boundaries so echo folds onto the low bits
    assign wram_idx = sel.addr[12:0];

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        dec_req.req.addr  <= sel.addr;
        dec_req.req.wdata <= sel.wdata;
        dec_req.region    <= region;
        dec_req.wram_addr <= wram_idx;
        if (rst) begin
            dec_req.req.rd  <= 1'b0;
            dec_req.req.wr  <= 1'b0;
            dec_req.req.dma <= 1'b0;
        end else begin
            dec_req.req.rd  <= sel.rd;
            dec_req.req.wr  <= sel.wr;
            dec_req.req.dma <= sel.dma & req_act;  // No stale flag on idle cycles
        end
    end

endmodule

`default_nettype wire

// ==== logic/gb_oam_dma.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gb_bus_defines.svh"

module gb_oam_dma (
    input  logic                clk,
    input  logic                rst,
    input  logic                dma_start,   // Pulse from FF46 write
    input  gb_bus_pkg::data_t   dma_page,    // Source page, high address byte
    input  logic                rsp_valid,
    input  logic                rsp_dma,
    input  gb_bus_pkg::data_t   rsp_data,
    output gb_bus_pkg::bus_req_t dma_req,
    output logic                dma_busy,
    output gb_bus_pkg::oam_wr_t oam_wr
);
    import gb_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,   // Waiting for a start pulse
        COPY,   // Issuing one read per cycle
        DRAIN   // All reads out, collecting the tail
    } dma_state_t;

    localparam oam_idx_t LAST_IDX = `DMA_LEN - 8'd1;

    dma_state_t state;
    oam_idx_t   issue_cnt;  // Next source byte to read
    oam_idx_t   rcv_cnt;    // Next OAM byte to write
    data_t      page_q;
    logic       rsp_hit;

    assign rsp_hit  = rsp_valid & rsp_dma;  // Only our own responses
    assign dma_busy = (state != IDLE);

    // Source read, low byte walks 00..9F
    always_comb begin
        dma_req.addr  = {page_q, issue_cnt};
        dma_req.wdata = '0;
        dma_req.rd    = (state == COPY);
        dma_req.wr    = 1'b0;
        dma_req.dma   = 1'b1;
    end

    // Each returning byte goes straight to OAM
    assign oam_wr.we   = rsp_hit;
    assign oam_wr.idx  = rcv_cnt;
    assign oam_wr.data = rsp_data;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            issue_cnt <= '0;
            rcv_cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dma_start) begin
                        state     <= COPY;
                        issue_cnt <= '0;
                        rcv_cnt   <= '0;
                    end
                end
                COPY: begin
                    issue_cnt <= issue_cnt + 8'd1;
                    if (issue_cnt == LAST_IDX) state <= DRAIN;  // Last read out
                end
                DRAIN: begin
                    // Two reads still in flight on entry
                    if (rsp_hit && rcv_cnt == LAST_IDX) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
            if (rsp_hit) rcv_cnt <= rcv_cnt + 8'd1;
        end
    end

    // Page is held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && dma_start) page_q <= dma_page;
    end

endmodule

`default_nettype wire

// ==== logic/gb_bus_pkg.sv ====
`default_nettype none

package gb_bus_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////
    typedef logic [15:0] addr_t;       // Full bus address
    typedef logic [7:0]  data_t;       // One bus byte
    typedef logic [4:0]  irq_t;        // 0 vblank, 1 lcdc, 2 timer, 3 serial, 4 joypad
    typedef logic [12:0] wram_addr_t;  // Index into 8 KiB work RAM
    typedef logic [7:0]  oam_idx_t;    // Sprite table byte, 0..159

    // Decoded targets on the bus
    typedef enum logic [3:0] {
        BOOT,       // Boot ROM overlay
        CART,       // Cart ROM and cart RAM
        WRAM,       // Work RAM and its echo
        JOYPAD,
        IF,
        IE,
        DMA,        // OAM DMA page register
        BOOTSTRAP,  // Overlay disable
        UNMAPPED    // Open bus
    } region_t;

    ////////////////////////////////////////
    // Pipeline bundles
    ////////////////////////////////////////
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  rd;    // Read strobe
        logic  wr;    // Write strobe
        logic  dma;   // Issued by the DMA engine
    } bus_req_t;

    typedef struct packed {
        bus_req_t   req;
        region_t    region;
        wram_addr_t wram_addr;  // Echo already folded
    } dec_req_t;

    typedef struct packed {
        addr_t addr;
        data_t dout;
        logic  wr;
        logic  rd;
        logic  cs;    // Cart RAM select
    } cart_bus_t;

    typedef struct packed {
        logic     we;
        oam_idx_t idx;
        data_t    data;
    } oam_wr_t;

endpackage

`default_nettype wire

// ==== include/gb_bus_defines.svh ====
`ifndef GB_BUS_DEFINES_SVH
`define GB_BUS_DEFINES_SVH

////////////////////////////////////////
// Memory map regions
////////////////////////////////////////

// Cartridge ROM, both banks
`define MEM_CART_START   16'h0000
`define MEM_CART_END     16'h7FFF

`define MEM_CRAM_START   16'hA000  // Cart RAM window
`define MEM_CRAM_END     16'hBFFF

`define MEM_WRAM_START   16'hC000  // 8 KiB internal work RAM
`define MEM_WRAM_END     16'hDFFF

// Echo of work RAM, stops short of OAM
`define MEM_ECHO_START   16'hE000
`define MEM_ECHO_END     16'hFDFF

`define BOOT_END         16'h00FF  // Last byte covered by boot overlay

////////////////////////////////////////
// I/O register addresses
////////////////////////////////////////
`define MMIO_JOYSTICK    16'hFF00
`define MMIO_IF          16'hFF0F  // Interrupt flags
`define MMIO_DMA         16'hFF46  // OAM DMA source page
`define MMIO_BOOTSTRAP   16'hFF50  // Boot ROM disable
`define MMIO_IE          16'hFFFF  // Interrupt enables

// Sprite attribute table length in bytes
`define DMA_LEN          8'd160

`define OPEN_BUS         8'hFF     // Value seen on undriven reads

`endif
